// ==== verilog.f ====
+incdir+hdl
+incdir+tb
hdl/asi_pkg.sv
hdl/symbol_timer.sv
hdl/ts_fifo.sv
hdl/fill_ctrl.sv
hdl/enc_8b10b.sv
hdl/serializer_10b1b.sv
hdl/ts2asi.sv
tb/tb_ts2asi.sv

// ==== tb/enc_ref.svh ====
`ifndef ENC_REF_SVH
`define ENC_REF_SVH

// Model 8b10b encoder, result is {disparity after, codeword}
// Disparity 1 is positive, codeword bit 0 is line bit a
function automatic logic [10:0] ref_encode(input asi_char_t ch, input logic rd_in);
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6;
	logic [3:0] c4;
	logic       rd_mid;
	logic       rd_out;
	logic       alt;
	logic [9:0] cw;
	x = ch.value[4:0];
	y = ch.value[7:5];
	// 5b/6b in the negative disparity form, a in the MSB
	case (x)
		5'd0:  c6 = 6'b100111;
		5'd1:  c6 = 6'b011101;
		5'd2:  c6 = 6'b101101;
		5'd3:  c6 = 6'b110001;
		5'd4:  c6 = 6'b110101;
		5'd5:  c6 = 6'b101001;
		5'd6:  c6 = 6'b011001;
		5'd7:  c6 = 6'b111000;
		5'd8:  c6 = 6'b111001;
		5'd9:  c6 = 6'b100101;
		5'd10: c6 = 6'b010101;
		5'd11: c6 = 6'b110100;
		5'd12: c6 = 6'b001101;
		5'd13: c6 = 6'b101100;
		5'd14: c6 = 6'b011100;
		5'd15: c6 = 6'b010111;
		5'd16: c6 = 6'b011011;
		5'd17: c6 = 6'b100011;
		5'd18: c6 = 6'b010011;
		5'd19: c6 = 6'b110010;
		5'd20: c6 = 6'b001011;
		5'd21: c6 = 6'b101010;
		5'd22: c6 = 6'b011010;
		5'd23: c6 = 6'b111010;
		5'd24: c6 = 6'b110011;
		5'd25: c6 = 6'b100110;
		5'd26: c6 = 6'b010110;
		5'd27: c6 = 6'b110110;
		5'd28: c6 = 6'b001110;
		5'd29: c6 = 6'b101110;
		5'd30: c6 = 6'b011110;
		default: c6 = 6'b101011;
	endcase
	// Only K28 goes out as a control character
	if (ch.k) c6 = 6'b001111;
	// Positive forms are complements, D.7 too although balanced
	if (rd_in && (($countones(c6) != 3) || (!ch.k && x == 5'd7))) c6 = ~c6;
	rd_mid = rd_in;
	if ($countones(c6) > 3) rd_mid = 1'b1;
	if ($countones(c6) < 3) rd_mid = 1'b0;
	// A7 breaks the run of five across the sub-blocks
	alt = ch.k || (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20))
		|| (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));
	// 3b/4b in the negative form, f in the MSB
	case (y)
		3'd0: c4 = 4'b1011;
		3'd1: c4 = 4'b1001;
		3'd2: c4 = 4'b0101;
		3'd3: c4 = 4'b1100;
		3'd4: c4 = 4'b1101;
		3'd5: c4 = 4'b1010;
		3'd6: c4 = 4'b0110;
		default: c4 = alt ? 4'b0111 : 4'b1110;
	endcase
	if (($countones(c4) != 2) || (y == 3'd3)) begin
		if (rd_mid) c4 = ~c4;
	end else if (ch.k && !rd_mid) begin
		// K28 inverts balanced fghj after a negative 6b block
		c4 = ~c4;
	end
	rd_out = rd_mid;
	if ($countones(c4) > 2) rd_out = 1'b1;
	if ($countones(c4) < 2) rd_out = 1'b0;
	// Line order abcdei fghj, a first
	for (int i = 0; i < 6; i++) cw[i] = c6[5 - i];
	for (int i = 0; i < 4; i++) cw[6 + i] = c4[3 - i];
	return {rd_out, cw};
endfunction

`endif

// ==== tb/tb_ts2asi.sv ====
`timescale 1ns/1ps
`include "asi_defs.svh"

module tb_ts2asi;
	import asi_pkg::*;

	`include "enc_ref.svh"

	localparam int N_SPARSE = 40;
	localparam int IDLE_SYMS = 20;
	localparam int BURST_LEN = 40;
	// First line bit of the first loaded word
	localparam int FIRST_BIT = 2 * `ASI_SYM_BITS;
	// Symbol budget per phase, drain time included
	localparam int SYNC_SYMS = 2 * (`ASI_SYNC_COMMAS + 12);
	localparam int SPARSE_SYMS = 2 * N_SPARSE + 8;
	localparam int RANGE_SYMS = (256 * 12) / `ASI_SYM_BITS + 8;
	localparam int BURST_SYMS = BURST_LEN + `ASI_FIFO_DEPTH + 8;
	localparam int PHASE_SYMS = SYNC_SYMS + SPARSE_SYMS + IDLE_SYMS + RANGE_SYMS + BURST_SYMS;
	localparam int CYCLE_LIMIT = PHASE_SYMS * `ASI_SYM_BITS + 1000;

	logic    clk;
	logic    rst;
	logic    valid;
	byte_t   din;
	logic    asi_out;
	logic    overflow;

	// Bytes written and not yet seen on the line
	byte_t   exp_q[$];
	int      errors;
	int      cyc;
	int      cycles;
	int      sym_idx;
	int      last_data_sym;
	int      skipped;
	int      run_len;
	logic    allow_drop;
	logic    rd_tb;
	logic    prev_ovf;
	logic    prev_bit;
	code10_t sym;

	ts2asi ts2asi_i (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.din      (din),
		.asi_out  (asi_out),
		.overflow (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Clocks since reset release, plus the watchdog count
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (!rst) cyc <= 0;
		else cyc <= cyc + 1;
	end

	always @(posedge clk) begin
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the line made no progress", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic asi_char_t make_char(input logic k, input byte_t value);
		asi_char_t c;
		c.k = k;
		c.value = value;
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Symbol checker
	//////////////////////////////////////////////////
	task automatic check_symbol();
		logic [10:0] res;
		logic [10:0] res_alt;
		logic        is_comma;
		logic        found;
		byte_t       exp_b;
		sym_idx++;
		res = ref_encode(make_char(1'b1, `ASI_COMMA_BYTE), rd_tb);
		res_alt = ref_encode(make_char(1'b1, `ASI_COMMA_BYTE), !rd_tb);
		// Either form is a comma, the form itself is checked below
		is_comma = (res[9:0] == sym) || (res_alt[9:0] == sym);
		// Sync phase sends nothing but commas
		if (sym_idx <= `ASI_SYNC_COMMAS) begin
			assert (is_comma) else begin
				$display("Error asi_out: sync symbol %0d expected 0x%h got 0x%h",
					sym_idx, res[9:0], sym);
				errors++;
			end
		end else if (sym_idx == `ASI_SYNC_COMMAS + 1) begin
			// Bytes written during sync go out right after it
			if (exp_q.size() > 0) begin
				assert (!is_comma) else begin
					$display("Error asi_out: symbol %0d expected data got comma 0x%h",
						sym_idx, sym);
					errors++;
				end
			end
		end
		if (is_comma) begin
			// Comma form follows running disparity, so idle commas alternate
			assert (sym == res[9:0]) else begin
				$display("Error asi_out: comma expected 0x%h got 0x%h", res[9:0], sym);
				errors++;
			end
			rd_tb = res[10];
		end else if (sym_idx > `ASI_SYNC_COMMAS) begin
			last_data_sym = sym_idx;
			found = 1'b0;
			// In a burst, dropped bytes are skipped over
			while (!found && exp_q.size() > 0) begin
				exp_b = exp_q.pop_front();
				res = ref_encode(make_char(1'b0, exp_b), rd_tb);
				if ((res[9:0] == sym) || !allow_drop) begin
					assert (res[9:0] == sym) else begin
						$display("Error asi_out: byte 0x%h expected 0x%h got 0x%h",
							exp_b, res[9:0], sym);
						errors++;
					end
					rd_tb = res[10];
					found = 1'b1;
				end else begin
					skipped++;
				end
			end
			assert (found) else begin
				$display("Data symbol 0x%h on the line matches no written byte", sym);
				errors++;
			end
		end
	endtask

	// Line capture, sampled mid-cycle
	always @(negedge clk) begin
		if (cyc == 0) begin
			rd_tb = 1'b0;
			sym_idx = 0;
			last_data_sym = 0;
			prev_ovf = 1'b0;
			run_len = 0;
		end else begin
			// Overflow holds until reset
			assert (!prev_ovf || overflow) else begin
				$display("Error overflow: expected 0x1 got 0x%h", overflow);
				errors++;
			end
			prev_ovf = overflow;
			if (cyc < FIRST_BIT) begin
				assert (asi_out == 1'b0) else begin
					$display("Error asi_out: expected 0x0 got 0x%h before first load", asi_out);
					errors++;
				end
			end else begin
				if ((run_len > 0) && (asi_out == prev_bit)) run_len++;
				else run_len = 1;
				prev_bit = asi_out;
				assert (run_len <= 5) else begin
					$display("Run of %0d equal bits on asi_out", run_len);
					errors++;
				end
				sym[(cyc - FIRST_BIT) % `ASI_SYM_BITS] = asi_out;
				if ((cyc - FIRST_BIT) % `ASI_SYM_BITS == `ASI_SYM_BITS - 1) check_symbol();
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic do_reset();
		@(negedge clk);
		rst = 1'b0;
		valid = 1'b0;
		repeat (3) @(negedge clk);
		// Bytes still in the FIFO are lost
		exp_q.delete();
		rst = 1'b1;
		assert (overflow == 1'b0) else begin
			$display("Error overflow: expected 0x0 got 0x%h after reset", overflow);
			errors++;
		end
	endtask

	task automatic send_byte(input byte_t b, input int gap);
		@(negedge clk);
		valid = 1'b1;
		din = b;
		exp_q.push_back(b);
		@(negedge clk);
		valid = 1'b0;
		repeat (gap - 1) @(negedge clk);
	endtask

	// Idle once a few commas follow the last data symbol
	// Polled on the rising edge, away from the capture updates
	task automatic wait_idle();
		int start;
		@(posedge clk);
		start = sym_idx;
		while ((sym_idx < start + 4) || (sym_idx - last_data_sym < 3)) @(posedge clk);
	endtask

	task automatic check_drained();
		assert (exp_q.size() == 0) else begin
			$display("%0d written bytes never reached the line", exp_q.size());
			errors++;
		end
	endtask

	initial begin
		int i;
		int missing;
		void'($urandom(32'he939_5654));
		rst = 1'b0;
		valid = 1'b0;
		din = '0;
		allow_drop = 1'b0;
		skipped = 0;
		errors = 0;
		missing = 0;
		do_reset();
		// Writes land during the sync commas
		for (i = 0; i < 4; i++) send_byte(8'(i * 17 + 3), 9);
		wait_idle();
		check_drained();
		// Sparse random bytes, at most one per symbol
		for (i = 0; i < N_SPARSE; i++) send_byte(8'($urandom), 9 + int'($urandom % 10));
		wait_idle();
		check_drained();
		// Nothing pending, fill commas only
		repeat (IDLE_SYMS * `ASI_SYM_BITS) @(negedge clk);
		// Every byte value, slow enough to never fill
		for (i = 0; i < 256; i++) send_byte(8'(i), 9 + int'($urandom % 3));
		wait_idle();
		check_drained();
		assert (overflow == 1'b0) else begin
			$display("Error overflow: expected 0x0 got 0x%h", overflow);
			errors++;
		end
		// Burst with valid on every clock
		skipped = 0;
		allow_drop = 1'b1;
		for (i = 0; i < BURST_LEN; i++) begin
			@(negedge clk);
			valid = 1'b1;
			din = 8'($urandom);
			exp_q.push_back(din);
		end
		@(negedge clk);
		valid = 1'b0;
		wait_idle();
		missing = skipped + exp_q.size();
		assert (overflow == (missing != 0)) else begin
			$display("Error overflow: expected 0x%h got 0x%h", missing != 0, overflow);
			errors++;
		end
		assert (missing != 0) else begin
			$display("Burst of %0d bytes lost none of them", BURST_LEN);
			errors++;
		end
		exp_q.delete();
		allow_drop = 1'b0;
		// Reset with bytes still in flight
		for (i = 0; i < 6; i++) send_byte(8'($urandom), 2);
		do_reset();
		for (i = 0; i < 4; i++) send_byte(8'(8'hF0 - i), 9);
		wait_idle();
		check_drained();
		$display("Errors: %0d, bytes lost in burst: %0d, cycles: %0d", errors, missing, cycles);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hdl/ts2asi.sv ====
`timescale 1ns/1ps

module ts2asi (
	input  logic           clk,
	input  logic           rst,
	input  logic           valid,
	input  asi_pkg::byte_t din,
	output logic           asi_out,
	output logic           overflow
);
	import asi_pkg::*;

	logic      sym_strobe;
	byte_t     head;
	logic      empty;
	logic      pop;
	asi_char_t tx_char;
	code10_t   code;

	// Symbol pace for the whole chain
	symbol_timer symbol_timer_i (
		.clk        (clk),
		.rst        (rst),
		.sym_strobe (sym_strobe)
	);

	// Input byte buffer
	ts_fifo ts_fifo_i (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.pop      (pop),
		.din      (din),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	// Data or comma per symbol
	fill_ctrl fill_ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.sym_strobe (sym_strobe),
		.empty      (empty),
		.head       (head),
		.pop        (pop),
		.tx_char    (tx_char)
	);

	enc_8b10b enc_8b10b_i (
		.clk        (clk),
		.rst        (rst),
		.sym_strobe (sym_strobe),
		.tx_char    (tx_char),
		.code       (code)
	);

	// Line output, one bit per clock
	serializer_10b1b serializer_10b1b_i (
		.clk        (clk),
		.rst        (rst),
		.sym_strobe (sym_strobe),
		.code       (code),
		.asi_out    (asi_out)
	);

endmodule

// ==== hdl/serializer_10b1b.sv ====
`timescale 1ns/1ps

module serializer_10b1b (
	input  logic             clk,
	input  logic             rst,
	input  logic             sym_strobe,
	input  asi_pkg::code10_t code,
	output logic             asi_out
);
	import asi_pkg::*;

	// Bits still waiting to go out
	code10_t sreg;

	//////////////////////////////////////////////////
	// Load on strobe, shift right otherwise
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			sreg <= '0;
			asi_out <= 1'b0;
		end else if (sym_strobe) begin
			// Bit 0 goes straight to the output flop
			asi_out <= code[0];
			sreg <= code >> 1;
		end else begin
			asi_out <= sreg[0];
			sreg <= sreg >> 1;
		end
	end

endmodule

// ==== hdl/enc_8b10b.sv ====
`timescale 1ns/1ps

module enc_8b10b (
	input  logic               clk,
	input  logic               rst,
	input  logic               sym_strobe,
	input  asi_pkg::asi_char_t tx_char,
	output asi_pkg::code10_t   code
);
	import asi_pkg::*;

	// Running disparity, 1 = positive
	logic rd;

	logic [4:0]  x;
	logic [2:0]  y;
	logic [11:0] pair6;
	logic [7:0]  pair4;
	logic [5:0]  s6;
	logic [3:0]  s4;
	logic        rd6;
	logic        use_a7;
	logic        rd_next;
	code10_t     code_next;

	//////////////////////////////////////////////////
	// 5b/6b table, {RD- form, RD+ form}, abcdei
	//////////////////////////////////////////////////
	function automatic logic [11:0] tab6(input logic [4:0] v);
		case (v)
			5'd0:  return {6'b100111, 6'b011000};
			5'd1:  return {6'b011101, 6'b100010};
			5'd2:  return {6'b101101, 6'b010010};
			5'd3:  return {6'b110001, 6'b110001};
			5'd4:  return {6'b110101, 6'b001010};
			5'd5:  return {6'b101001, 6'b101001};
			5'd6:  return {6'b011001, 6'b011001};
			5'd7:  return {6'b111000, 6'b000111};
			5'd8:  return {6'b111001, 6'b000110};
			5'd9:  return {6'b100101, 6'b100101};
			5'd10: return {6'b010101, 6'b010101};
			5'd11: return {6'b110100, 6'b110100};
			5'd12: return {6'b001101, 6'b001101};
			5'd13: return {6'b101100, 6'b101100};
			5'd14: return {6'b011100, 6'b011100};
			5'd15: return {6'b010111, 6'b101000};
			5'd16: return {6'b011011, 6'b100100};
			5'd17: return {6'b100011, 6'b100011};
			5'd18: return {6'b010011, 6'b010011};
			5'd19: return {6'b110010, 6'b110010};
			5'd20: return {6'b001011, 6'b001011};
			5'd21: return {6'b101010, 6'b101010};
			5'd22: return {6'b011010, 6'b011010};
			5'd23: return {6'b111010, 6'b000101};
			5'd24: return {6'b110011, 6'b001100};
			5'd25: return {6'b100110, 6'b100110};
			5'd26: return {6'b010110, 6'b010110};
			5'd27: return {6'b110110, 6'b001001};
			5'd28: return {6'b001110, 6'b001110};
			5'd29: return {6'b101110, 6'b010001};
			5'd30: return {6'b011110, 6'b100001};
			default: return {6'b101011, 6'b010100};
		endcase
	endfunction

	//////////////////////////////////////////////////
	// 3b/4b table, {RD- form, RD+ form}, fghj
	//////////////////////////////////////////////////
	function automatic logic [7:0] tab4(input logic [2:0] v, input logic a7, input logic k);
		logic [7:0] p;
		case (v)
			3'd0: p = {4'b1011, 4'b0100};
			3'd1: p = {4'b1001, 4'b1001};
			3'd2: p = {4'b0101, 4'b0101};
			3'd3: p = {4'b1100, 4'b0011};
			3'd4: p = {4'b1101, 4'b0010};
			3'd5: p = {4'b1010, 4'b1010};
			3'd6: p = {4'b0110, 4'b0110};
			default: p = a7 ? {4'b0111, 4'b1000} : {4'b1110, 4'b0001};
		endcase
		// K28 flips the balanced sub-blocks after a negative 6b
		if (k && (v inside {3'd1, 3'd2, 3'd5, 3'd6})) p[7:4] = ~p[3:0];
		return p;
	endfunction

	always_comb begin
		x = tx_char.value[4:0];
		y = tx_char.value[7:5];
		// Only K28 is supported as a control character
		pair6 = tx_char.k ? {6'b001111, 6'b110000} : tab6(x);
		s6 = rd ? pair6[5:0] : pair6[11:6];
		// Disparity after the 6b sub-block
		rd6 = rd ^ ($countones(s6) != 3);
		// Alternate D.x.7 avoids a run of five
		use_a7 = tx_char.k
			|| (!rd6 && (x inside {5'd17, 5'd18, 5'd20}))
			|| (rd6 && (x inside {5'd11, 5'd13, 5'd14}));
		pair4 = tab4(y, use_a7, tx_char.k);
		s4 = rd6 ? pair4[3:0] : pair4[7:4];
		rd_next = rd6 ^ ($countones(s4) != 2);
		// Bit a lands in bit 0, j in bit 9
		code_next = {s4[0], s4[1], s4[2], s4[3], s6[0], s6[1], s6[2], s6[3], s6[4], s6[5]};
	end

	// Codeword and disparity register
	always_ff @(posedge clk) begin
		if (!rst) begin
			code <= '0;
			rd <= 1'b0;
		end else if (sym_strobe) begin
			code <= code_next;
			rd <= rd_next;
		end
	end

endmodule

// ==== hdl/fill_ctrl.sv ====
`timescale 1ns/1ps
`include "asi_defs.svh"

module fill_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              sym_strobe,
	input  logic              empty,
	input  asi_pkg::byte_t    head,
	output logic              pop,
	output asi_pkg::asi_char_t tx_char
);
	import asi_pkg::*;

	localparam int SCW = $clog2(`ASI_SYNC_COMMAS + 1);
	localparam logic [SCW-1:0] SYNC_LAST = SCW'(`ASI_SYNC_COMMAS - 1);

	fill_state_t state;
	// Commas already sent in SYNC
	logic [SCW-1:0] sync_cnt;

	//////////////////////////////////////////////////
	// State register, moves only on symbol strobes
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= SYNC;
			sync_cnt <= '0;
		end else if (sym_strobe) begin
			case (state)
				SYNC: begin
					// Last sync comma goes out on this strobe
					if (sync_cnt == SYNC_LAST) begin
						state <= STREAM;
					end else begin
						sync_cnt <= sync_cnt + 1'b1;
					end
				end
				default: state <= STREAM;
			endcase
		end
	end

	// Take the head byte only when it is actually sent
	assign pop = sym_strobe && (state == STREAM) && !empty;

	// Character choice for this symbol
	always_comb begin
		tx_char.k = 1'b1;
		tx_char.value = `ASI_COMMA_BYTE;
		if ((state == STREAM) && !empty) begin
			tx_char.k = 1'b0;
			tx_char.value = head;
		end
	end

endmodule

// ==== hdl/ts_fifo.sv ====
`timescale 1ns/1ps
`include "asi_defs.svh"

module ts_fifo (
	input  logic           clk,
	input  logic           rst,
	input  logic           valid,
	input  logic           pop,
	input  asi_pkg::byte_t din,
	output asi_pkg::byte_t head,
	output logic           empty,
	output logic           overflow
);
	import asi_pkg::*;

	localparam int DEPTH = `ASI_FIFO_DEPTH;
	localparam int AW = `ASI_FIFO_AW;

	// Byte storage
	byte_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          wr_en;
	logic          rd_en;

	// Circular pointer advance
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	// A pop in the same cycle frees a slot
	assign wr_en = valid && (!full || pop);
	assign rd_en = pop && !empty;

	// Head is visible with no read latency
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	//////////////////////////////////////////////////
	// Pointers, fill count, sticky overflow
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Dropped byte, held until the next reset
			if (valid && !wr_en) overflow <= 1'b1;
		end
	end

endmodule

// ==== hdl/symbol_timer.sv ====
`timescale 1ns/1ps
`include "asi_defs.svh"

module symbol_timer (
	input  logic clk,
	input  logic rst,
	output logic sym_strobe
);

	localparam int CW = $clog2(`ASI_SYM_BITS);
	localparam logic [CW-1:0] LAST = CW'(`ASI_SYM_BITS - 1);

	// Bit position within the current symbol
	logic [CW-1:0] count;

	//////////////////////////////////////////////////
	// Mod-10 bit counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// One pulse per symbol, on the last bit slot
	// Count is cleared in reset so the strobe stays low there
	assign sym_strobe = (count == LAST);

endmodule

// ==== hdl/asi_pkg.sv ====
`include "asi_defs.svh"

package asi_pkg;

	// Transport-stream byte
	typedef logic [7:0] byte_t;

	// Line codeword, bit 0 goes out first
	typedef logic [`ASI_SYM_BITS-1:0] code10_t;

	// One character ahead of the encoder
	typedef struct packed {
		logic  k;
		byte_t value;
	} asi_char_t;

	// Fill controller states
	typedef enum logic {
		SYNC,
		STREAM
	} fill_state_t;

endpackage

// ==== hdl/asi_defs.svh ====
`ifndef ASI_DEFS_SVH
`define ASI_DEFS_SVH

// FIFO geometry
`define ASI_FIFO_DEPTH 16
`define ASI_FIFO_AW 4

// Commas sent after reset before the first data byte
`define ASI_SYNC_COMMAS 4

// Line bits per 8b10b symbol
`define ASI_SYM_BITS 10

// Data value of K28.5
`define ASI_COMMA_BYTE 8'hBC

`endif
